/* verilog/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Cache geometry.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // 8 bytes per line.
  localparam int offset_bits = 3;

  // 16 direct-mapped lines.
  localparam int index_bits = 4;

  localparam int tag_bits = 32 - offset_bits - index_bits;

  localparam int line_count = 2 ** index_bits;

  // Refill beats of one word each.
  localparam int burst_beats = 2;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Address map.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // First fetch address after reset.
  localparam logic [31:0] reset_pc = 32'h3000_0000;

  // Top address byte that is never cached.
  localparam logic [7:0] uncached_region = 8'h0f;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Types.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef logic [31:0] word_t;

  // Low word sits at the lower address.
  typedef logic [63:0] line_t;

  typedef enum logic {
    fetch_lookup,
    fetch_refill
  } fetch_state_t;

endpackage

`default_nettype wire

/* verilog/icache_store.sv */
`default_nettype none
`timescale 1ns/1ps

module icache_store
  import fetch_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  word_t lookup_addr,
  output logic  hit,
  output word_t hit_word,
  input  logic  line_strobe,
  input  word_t line_addr,
  input  line_t line_data,
  input  logic  flush
);

  logic [line_count-1:0] valid;
  logic [tag_bits-1:0]   tags [line_count];
  line_t                 lines [line_count];

  logic [index_bits-1:0] lookup_index;
  logic [tag_bits-1:0]   lookup_tag;
  logic                  lookup_cacheable;
  line_t                 lookup_line;

  logic [index_bits-1:0] fill_index;
  logic                  fill_write;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Combinational lookup path.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign lookup_index     = lookup_addr[offset_bits +: index_bits];
  assign lookup_tag       = lookup_addr[31 -: tag_bits];
  assign lookup_cacheable = lookup_addr[31:24] != uncached_region;
  assign lookup_line      = lines[lookup_index];

  assign hit = valid[lookup_index] && tags[lookup_index] == lookup_tag &&
               lookup_cacheable;

  // Upper word for odd word addresses.
  assign hit_word = lookup_addr[offset_bits-1] ? lookup_line[63:32] : lookup_line[31:0];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Fill and flush.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign fill_index = line_addr[offset_bits +: index_bits];
  assign fill_write = line_strobe && line_addr[31:24] != uncached_region;

  // Flush beats a fill in the same cycle.
  always_ff @(posedge clock) begin
    if (reset || flush) begin
      valid <= '0;
    end else if (fill_write) begin
      valid[fill_index] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (fill_write) begin
      tags[fill_index]  <= line_addr[31 -: tag_bits];
      lines[fill_index] <= line_data;
    end
  end

  // No valid line may ever hold an uncached tag.
  uncached_never_hits: assert property (
    @(posedge clock) disable iff (reset)
      lookup_addr[31:24] == uncached_region |->
        !(valid[lookup_index] && tags[lookup_index] == lookup_tag)
  );

endmodule

`default_nettype wire

/* verilog/burst_reader.sv */
`default_nettype none
`timescale 1ns/1ps

module burst_reader
  import fetch_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  logic  refill_start,
  input  word_t refill_addr,
  output word_t araddr,
  output logic  arvalid,
  input  logic  arready,
  input  word_t rdata,
  input  logic  rvalid,
  input  logic  rlast,
  output logic  rready,
  output logic  line_strobe,
  output word_t line_addr,
  output line_t line_data
);

  word_t req_addr;
  word_t first_word;
  logic  beat_done;

  logic [$clog2(burst_beats)-1:0] beat;

  assign beat_done = rready && rvalid;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Address and data phases.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clock) begin
    if (reset) begin
      arvalid <= 1'b0;
      rready  <= 1'b0;
      beat    <= '0;
    end else begin
      if (refill_start) begin
        arvalid <= 1'b1;
      end else if (arvalid && arready) begin
        arvalid <= 1'b0;
        rready  <= 1'b1;
      end else if (beat_done) begin
        if (rlast) begin
          rready <= 1'b0;
          beat   <= '0;
        end else begin
          beat <= beat + 1'b1;
        end
      end
    end
  end

  // Request address is line aligned.
  always_ff @(posedge clock) begin
    if (refill_start) begin
      req_addr <= {refill_addr[31:offset_bits], {offset_bits{1'b0}}};
    end
  end

  // Hold the low word until the last beat shows up.
  always_ff @(posedge clock) begin
    if (beat_done && !rlast) begin
      first_word <= rdata;
    end
  end

  assign araddr      = req_addr;
  assign line_addr   = req_addr;
  assign line_strobe = beat_done && rlast;
  assign line_data   = {rdata, first_word};

  // Only one refill outstanding.
  no_overlapping_refill: assert property (
    @(posedge clock) disable iff (reset)
      refill_start |-> !(arvalid || rready)
  );

  last_on_final_beat: assert property (
    @(posedge clock) disable iff (reset)
      beat_done |-> rlast == (beat == burst_beats - 1)
  );

endmodule

`default_nettype wire

/* verilog/fetch_control.sv */
`default_nettype none
`timescale 1ns/1ps

module fetch_control
  import fetch_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  logic  redirect,
  input  word_t redirect_pc,
  input  logic  decode_ready,
  output logic  inst_valid,
  output word_t inst,
  output word_t inst_pc,
  output word_t lookup_addr,
  input  logic  hit,
  input  word_t hit_word,
  output logic  refill_start,
  output word_t refill_addr,
  input  logic  line_strobe,
  input  line_t line_data
);

  fetch_state_t state;
  word_t        pc;
  logic         discard;

  logic  out_ready;
  logic  do_lookup;
  logic  load_hit;
  logic  load_fill;
  logic  start_miss;
  logic  refill_done;
  word_t fill_word;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Decisions for this cycle.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Output register is empty or drains this cycle.
  assign out_ready = !inst_valid || decode_ready;

  assign do_lookup   = state == fetch_lookup && out_ready && !redirect;
  assign load_hit    = do_lookup && hit;
  assign start_miss  = do_lookup && !hit;
  assign refill_done = state == fetch_refill && line_strobe;
  assign load_fill   = refill_done && !discard && !redirect;

  assign fill_word = pc[2] ? line_data[63:32] : line_data[31:0];

  assign lookup_addr = pc;
  assign refill_addr = pc;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // PC, state and output valid.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clock) begin
    if (reset) begin
      pc           <= reset_pc;
      state        <= fetch_lookup;
      discard      <= 1'b0;
      inst_valid   <= 1'b0;
      refill_start <= 1'b0;
    end else begin
      refill_start <= start_miss;

      if (refill_done) begin
        state   <= fetch_lookup;
        discard <= 1'b0;
      end

      if (redirect) begin
        pc         <= redirect_pc;
        inst_valid <= 1'b0;
        // Let the burst finish but drop its word.
        if (state == fetch_refill && !line_strobe) begin
          discard <= 1'b1;
        end
      end else begin
        if (inst_valid && decode_ready) begin
          inst_valid <= 1'b0;
        end
        if (load_hit || load_fill) begin
          inst_valid <= 1'b1;
          pc         <= pc + 32'd4;
        end
        if (start_miss) begin
          state <= fetch_refill;
        end
      end
    end
  end

  // Instruction and its address.
  always_ff @(posedge clock) begin
    if (load_hit) begin
      inst    <= hit_word;
      inst_pc <= pc;
    end else if (load_fill) begin
      inst    <= fill_word;
      inst_pc <= pc;
    end
  end

  // Held output must not change under back-pressure.
  output_stable_while_stalled: assert property (
    @(posedge clock) disable iff (reset)
      inst_valid && !decode_ready |=> $stable(inst) && $stable(inst_pc)
  );

endmodule

`default_nettype wire

/* verilog/fetch_unit.sv */
`default_nettype none
`timescale 1ns/1ps

module fetch_unit
  import fetch_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  logic  redirect,
  input  word_t redirect_pc,
  input  logic  flush,
  input  logic  decode_ready,
  output logic  inst_valid,
  output word_t inst,
  output word_t inst_pc,
  output word_t araddr,
  output logic  arvalid,
  input  logic  arready,
  input  word_t rdata,
  input  logic  rvalid,
  input  logic  rlast,
  output logic  rready
);

  word_t lookup_addr;
  logic  hit;
  word_t hit_word;
  logic  refill_start;
  word_t refill_addr;
  logic  line_strobe;
  word_t line_addr;
  line_t line_data;

  icache_store icache_store_i (
    .clock       (clock),
    .reset       (reset),
    .lookup_addr (lookup_addr),
    .hit         (hit),
    .hit_word    (hit_word),
    .line_strobe (line_strobe),
    .line_addr   (line_addr),
    .line_data   (line_data),
    .flush       (flush)
  );

  burst_reader burst_reader_i (
    .clock        (clock),
    .reset        (reset),
    .refill_start (refill_start),
    .refill_addr  (refill_addr),
    .araddr       (araddr),
    .arvalid      (arvalid),
    .arready      (arready),
    .rdata        (rdata),
    .rvalid       (rvalid),
    .rlast        (rlast),
    .rready       (rready),
    .line_strobe  (line_strobe),
    .line_addr    (line_addr),
    .line_data    (line_data)
  );

  fetch_control fetch_control_i (
    .clock        (clock),
    .reset        (reset),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc),
    .decode_ready (decode_ready),
    .inst_valid   (inst_valid),
    .inst         (inst),
    .inst_pc      (inst_pc),
    .lookup_addr  (lookup_addr),
    .hit          (hit),
    .hit_word     (hit_word),
    .refill_start (refill_start),
    .refill_addr  (refill_addr),
    .line_strobe  (line_strobe),
    .line_data    (line_data)
  );

endmodule

`default_nettype wire

/* tb/fetch_memory_model.sv */
`default_nettype none
`timescale 1ns/1ps

module fetch_memory_model
  import fetch_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  word_t araddr,
  input  logic  arvalid,
  output logic  arready,
  output word_t rdata,
  output logic  rvalid,
  output logic  rlast,
  input  logic  rready,
  output int    burst_count
);

  integer seed = 4;
  word_t  base;

  // Each call ends 1 ns after a rising edge.
  task automatic wait_cycles(input int count);
    repeat (count) begin
      @(posedge clock);
      #1;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read-channel slave.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    arready     = 1'b0;
    rvalid      = 1'b0;
    rlast       = 1'b0;
    rdata       = '0;
    burst_count = 0;
    forever begin
      wait_cycles(1);
      if (!reset && arvalid) begin
        base = araddr;
        wait_cycles($random(seed) & 3);
        arready = 1'b1;
        wait_cycles(1);
        arready     = 1'b0;
        burst_count = burst_count + 1;
        for (int beat = 0; beat < burst_beats; beat++) begin
          wait_cycles($random(seed) & 3);
          while (!rready) begin
            wait_cycles(1);
          end
          // Data word is the byte address scrambled with a fixed key.
          rdata  = (base + 4 * beat) ^ 32'h5a5a_5a5a;
          rvalid = 1'b1;
          rlast  = beat == burst_beats - 1;
          wait_cycles(1);
          rvalid = 1'b0;
          rlast  = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* tb/fetch_unit_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module fetch_unit_tb
  import fetch_pkg::*;
();

  localparam word_t data_key          = 32'h5a5a_5a5a;
  localparam word_t uncached_base     = {uncached_region, 24'h00_0000};
  localparam word_t backpressure_base = reset_pc + 32'h100;
  localparam word_t detour_pc         = reset_pc + 32'h400;
  localparam word_t redirect_target   = reset_pc + 32'h800;
  localparam int    cycle_limit       = 6 * 64 * 12;

  logic   clock = 1'b0;
  logic   reset;
  logic   redirect;
  word_t  redirect_pc;
  logic   flush;
  logic   decode_ready;
  logic   inst_valid;
  word_t  inst;
  word_t  inst_pc;
  word_t  araddr;
  logic   arvalid;
  logic   arready;
  word_t  rdata;
  logic   rvalid;
  logic   rlast;
  logic   rready;
  int     burst_count;
  int     cycles = 0;
  integer seed = 4;
  logic   stall_decode = 1'b0;

  fetch_unit fetch_unit_i (
    .clock        (clock),
    .reset        (reset),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc),
    .flush        (flush),
    .decode_ready (decode_ready),
    .inst_valid   (inst_valid),
    .inst         (inst),
    .inst_pc      (inst_pc),
    .araddr       (araddr),
    .arvalid      (arvalid),
    .arready      (arready),
    .rdata        (rdata),
    .rvalid       (rvalid),
    .rlast        (rlast),
    .rready       (rready)
  );

  fetch_memory_model memory_i (
    .clock       (clock),
    .reset       (reset),
    .araddr      (araddr),
    .arvalid     (arvalid),
    .arready     (arready),
    .rdata       (rdata),
    .rvalid      (rvalid),
    .rlast       (rlast),
    .rready      (rready),
    .burst_count (burst_count)
  );

  always #4 clock = ~clock;

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout, the tests did not finish within %0d cycles.", cycle_limit);
      stop_failed();
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Compare tasks.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic stop_failed();
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("** Error %s: inst expected %h, actual %h", name, expected, actual);
      stop_failed();
    end
  endtask

  task automatic check_pc(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("** Error %s: pc expected %h, actual %h", name, expected, actual);
      stop_failed();
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("** Error %s: bursts expected %0d, actual %0d", name, expected, actual);
      stop_failed();
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Decoder side.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  // Any valid output before acceptance must already be this instruction.
  // On the last one, redirect and flush share the accepting cycle.
  task automatic take_inst(input string name, input word_t expect_pc, input logic last,
                           input word_t next_pc, input logic flush_at_end);
    logic accepted;
    accepted = 1'b0;
    while (!accepted) begin
      decode_ready = !stall_decode || last || ($random(seed) & 3) != 0;
      if (inst_valid) begin
        check_pc(name, expect_pc, inst_pc);
        check_word(name, expect_pc ^ data_key, inst);
        accepted = decode_ready;
      end
      if (accepted && last) begin
        redirect    = 1'b1;
        redirect_pc = next_pc;
        flush       = flush_at_end;
      end
      next_cycle();
      redirect = 1'b0;
      flush    = 1'b0;
    end
    decode_ready = 1'b1;
  endtask

  task automatic fetch_run(input string name, input word_t first_pc, input int count,
                           input word_t next_pc, input logic flush_at_end);
    for (int i = 0; i < count; i++) begin
      take_inst(name, word_t'(first_pc + 4 * i), i == count - 1, next_pc, flush_at_end);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Directed tests.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic sequential_fetch();
    int start;
    start = burst_count;
    fetch_run("sequential", reset_pc, 32, reset_pc, 1'b0);
    check_count("sequential", start + 16, burst_count);
  endtask

  task automatic cached_refetch();
    int start;
    start = burst_count;
    fetch_run("hits", reset_pc, 32, uncached_base, 1'b0);
    check_count("hits", start, burst_count);
  endtask

  task automatic uncached_fetch();
    int start;
    start = burst_count;
    fetch_run("uncached", uncached_base, 8, uncached_base, 1'b0);
    check_count("uncached", start + 8, burst_count);
    fetch_run("uncached again", uncached_base, 8, backpressure_base, 1'b0);
    check_count("uncached again", start + 16, burst_count);
  endtask

  task automatic stalled_decode();
    stall_decode = 1'b1;
    fetch_run("backpressure", backpressure_base, 40, detour_pc, 1'b0);
    stall_decode = 1'b0;
  endtask

  // Detour line misses, so arvalid means a refill is in flight.
  task automatic redirect_in_refill();
    while (!arvalid) begin
      next_cycle();
    end
    redirect    = 1'b1;
    redirect_pc = redirect_target;
    next_cycle();
    redirect = 1'b0;
    fetch_run("redirect", redirect_target, 4, reset_pc, 1'b0);
  endtask

  task automatic flush_refetch();
    int start;
    fetch_run("flush fill", reset_pc, 32, reset_pc, 1'b1);
    start = burst_count;
    fetch_run("flush", reset_pc, 32, reset_pc, 1'b0);
    check_count("flush", start + 16, burst_count);
  endtask

  initial begin
    reset        = 1'b1;
    redirect     = 1'b0;
    redirect_pc  = '0;
    flush        = 1'b0;
    decode_ready = 1'b1;
    repeat (4) @(posedge clock);
    #1;
    reset = 1'b0;

    sequential_fetch();
    cached_refetch();
    uncached_fetch();
    stalled_decode();
    redirect_in_refill();
    flush_refetch();

    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* fetch_unit.f */
verilog/fetch_pkg.sv
verilog/icache_store.sv
verilog/burst_reader.sv
verilog/fetch_control.sv
verilog/fetch_unit.sv
tb/fetch_memory_model.sv
tb/fetch_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module fetch_unit_tb \
  -f fetch_unit.f -o fetch_unit_sim &&
  ./obj_dir/fetch_unit_sim | tee /dev/stderr | grep -q "^test passed$" &&
  echo "simulation ok" ||
  { echo "simulation not ok"; exit 1; }
